/* logic/ex_pkg.sv */
package ex_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // rv32i major opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_sr      = 3'b101; // srl / sra by bit 30
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_lb  = 3'b000;
    localparam logic [2:0] f3_lh  = 3'b001;
    localparam logic [2:0] f3_lw  = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [2:0] {
        cls_alu,
        cls_load,
        cls_store,
        cls_branch,
        cls_jump,
        cls_none
    } ex_class_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef struct packed {
        logic [31:0]           inst;
        logic                  reg_we;
        logic [reg_addr_w-1:0] reg_waddr;
        logic [xlen-1:0]       reg1_rdata;
        logic [xlen-1:0]       reg2_rdata;
        logic [xlen-1:0]       op1;
        logic [xlen-1:0]       op2;
        logic [xlen-1:0]       op1_jump;
        logic [xlen-1:0]       op2_jump;
    } ex_in_t;

    typedef struct packed {
        alu_op_e         op;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [4:0]      shamt;
    } alu_req_t;

    typedef struct packed {
        logic            req;
        logic            we;
        logic [xlen-1:0] raddr;
        logic [xlen-1:0] waddr;
        logic [xlen-1:0] wdata;
    } ex_mem_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } ex_wb_t;

    typedef struct packed {
        logic            flag;
        logic [xlen-1:0] addr;
    } ex_jump_t;

endpackage

/* logic/ex_decode.sv */
`timescale 1ns/1ns

module ex_decode (
    input  ex_pkg::ex_in_t    ex_in_i,
    output ex_pkg::ex_class_e class_o,
    output ex_pkg::alu_req_t  alu_req_o
);

    import ex_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;

    assign opcode = ex_in_i.inst[6:0];
    assign funct3 = ex_in_i.inst[14:12];
    assign funct7 = ex_in_i.inst[31:25];
    assign alt    = ex_in_i.inst[30]; // sub / sra select

    always_comb begin
        class_o         = cls_none;
        alu_req_o.op    = alu_add;
        alu_req_o.a     = ex_in_i.op1;
        alu_req_o.b     = ex_in_i.op2;
        alu_req_o.shamt = (opcode == op_imm) ? ex_in_i.inst[24:20] : ex_in_i.op2[4:0];
        case (opcode)
            op_imm, op_reg: begin
                // m-extension and other funct7 values fall to cls_none
                if (opcode == op_imm || funct7 == 7'b0000000 || funct7 == 7'b0100000) begin
                    class_o = cls_alu;
                end
                case (funct3)
                    f3_add_sub: alu_req_o.op = (opcode == op_reg && alt) ? alu_sub : alu_add;
                    f3_sll:     alu_req_o.op = alu_sll;
                    f3_slt:     alu_req_o.op = alu_slt;
                    f3_sltu:    alu_req_o.op = alu_sltu;
                    f3_xor:     alu_req_o.op = alu_xor;
                    f3_sr:      alu_req_o.op = alt ? alu_sra : alu_srl;
                    f3_or:      alu_req_o.op = alu_or;
                    default:    alu_req_o.op = alu_and;
                endcase
            end
            op_load: begin
                if (funct3 inside {f3_lb, f3_lh, f3_lw, f3_lbu, f3_lhu}) begin
                    class_o = cls_load;
                end
            end
            op_store: begin
                if (funct3 inside {f3_sb, f3_sh, f3_sw}) begin
                    class_o = cls_store;
                end
            end
            op_branch: begin
                if (funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu}) begin
                    class_o = cls_branch;
                end
            end
            op_jal, op_jalr:  class_o = cls_jump;  // link value is op1 + op2
            op_lui, op_auipc: class_o = cls_alu;
            default:          class_o = cls_none;
        endcase
    end

endmodule

/* logic/ex_alu.sv */
`timescale 1ns/1ns

module ex_alu (
    input  ex_pkg::alu_req_t        alu_req_i,
    output logic [ex_pkg::xlen-1:0] result_o
);

    import ex_pkg::*;

    logic        [xlen-1:0] a;
    logic        [xlen-1:0] b;
    logic signed [xlen-1:0] a_s;
    logic        [4:0]      shamt;
    logic                   lt_s;
    logic                   lt_u;

    assign a     = alu_req_i.a;
    assign b     = alu_req_i.b;
    assign a_s   = alu_req_i.a;
    assign shamt = alu_req_i.shamt;

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (alu_req_i.op)
            alu_add:  result_o = a + b;
            alu_sub:  result_o = a - b;
            alu_sll:  result_o = a << shamt;
            alu_slt:  result_o = {{(xlen-1){1'b0}}, lt_s};
            alu_sltu: result_o = {{(xlen-1){1'b0}}, lt_u};
            alu_xor:  result_o = a ^ b;
            alu_srl:  result_o = a >> shamt;
            alu_sra:  result_o = a_s >>> shamt; // sign fill from a
            alu_or:   result_o = a | b;
            alu_and:  result_o = a & b;
            default:  result_o = '0;
        endcase
    end

endmodule

/* logic/ex_branch.sv */
`timescale 1ns/1ns

module ex_branch (
    input  ex_pkg::ex_class_e class_i,
    input  ex_pkg::ex_in_t    ex_in_i,
    output ex_pkg::ex_jump_t  jump_o
);

    import ex_pkg::*;

    logic [xlen-1:0] target;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            taken;

    assign target = ex_in_i.op1_jump + ex_in_i.op2_jump;
    assign eq     = ex_in_i.op1 == ex_in_i.op2;
    assign lt_s   = $signed(ex_in_i.op1) < $signed(ex_in_i.op2);
    assign lt_u   = ex_in_i.op1 < ex_in_i.op2;

    always_comb begin
        taken = 1'b0;
        if (class_i == cls_jump) begin
            taken = 1'b1;
        end else if (class_i == cls_branch) begin
            case (ex_in_i.inst[14:12])
                f3_beq:  taken = eq;
                f3_bne:  taken = !eq;
                f3_blt:  taken = lt_s;
                f3_bge:  taken = !lt_s;
                f3_bltu: taken = lt_u;
                f3_bgeu: taken = !lt_u;
                default: taken = 1'b0;
            endcase
        end
        jump_o.flag = taken;
        jump_o.addr = taken ? target : '0; // zero when not taken
    end

endmodule

/* logic/ex_mem_align.sv */
`timescale 1ns/1ns

module ex_mem_align (
    input  ex_pkg::ex_class_e       class_i,
    input  ex_pkg::ex_in_t          ex_in_i,
    input  logic [ex_pkg::xlen-1:0] mem_rdata_i,
    output ex_pkg::ex_mem_t         mem_o,
    output logic [ex_pkg::xlen-1:0] load_data_o
);

    import ex_pkg::*;

    logic [xlen-1:0] addr;
    logic [1:0]      lane;
    logic [2:0]      funct3;
    logic [7:0]      byte_sel;
    logic [15:0]     half_sel;
    logic [7:0]      st_byte;
    logic [15:0]     st_half;

    assign addr    = ex_in_i.op1 + ex_in_i.op2;
    assign lane    = addr[1:0];
    assign funct3  = ex_in_i.inst[14:12];
    assign st_byte = ex_in_i.reg2_rdata[7:0];
    assign st_half = ex_in_i.reg2_rdata[15:0];

    // load lane pick
    always_comb begin
        case (lane)
            2'd0:    byte_sel = mem_rdata_i[7:0];
            2'd1:    byte_sel = mem_rdata_i[15:8];
            2'd2:    byte_sel = mem_rdata_i[23:16];
            default: byte_sel = mem_rdata_i[31:24];
        endcase
        half_sel = lane[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];
        case (funct3)
            f3_lb:   load_data_o = {{(xlen-8){byte_sel[7]}}, byte_sel};
            f3_lh:   load_data_o = {{(xlen-16){half_sel[15]}}, half_sel};
            f3_lw:   load_data_o = mem_rdata_i;
            f3_lbu:  load_data_o = {{(xlen-8){1'b0}}, byte_sel};
            f3_lhu:  load_data_o = {{(xlen-16){1'b0}}, half_sel};
            default: load_data_o = '0;
        endcase
    end

    always_comb begin
        mem_o = '0;
        if (class_i == cls_load) begin
            mem_o.req   = 1'b1;
            mem_o.raddr = addr;
        end else if (class_i == cls_store) begin
            mem_o.req   = 1'b1;
            mem_o.we    = 1'b1;
            mem_o.waddr = addr;
            mem_o.raddr = addr; // read back word for the merge
            mem_o.wdata = mem_rdata_i;
            case (funct3)
                f3_sb:   mem_o.wdata[{lane, 3'b000} +: 8] = st_byte;
                f3_sh:   mem_o.wdata[{lane[1], 4'b0000} +: 16] = st_half;
                f3_sw:   mem_o.wdata = ex_in_i.reg2_rdata;
                default: mem_o.wdata = mem_rdata_i;
            endcase
        end
    end

endmodule

/* logic/ex_result_reg.sv */
`timescale 1ns/1ns

module ex_result_reg (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  ex_pkg::ex_class_e       class_i,
    input  ex_pkg::ex_in_t          ex_in_i,
    input  logic [ex_pkg::xlen-1:0] alu_result_i,
    input  logic [ex_pkg::xlen-1:0] load_data_i,
    input  ex_pkg::ex_jump_t        jump_i,
    output ex_pkg::ex_wb_t          wb_o,
    output ex_pkg::ex_jump_t        jump_o
);

    import ex_pkg::*;

    ex_wb_t wb_d;

    // we follows decode even when nothing useful is written
    always_comb begin
        wb_d.we    = ex_in_i.reg_we;
        wb_d.waddr = ex_in_i.reg_waddr;
        case (class_i)
            cls_load:          wb_d.wdata = load_data_i;
            cls_alu, cls_jump: wb_d.wdata = alu_result_i;
            default:           wb_d.wdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_o   <= '0;
            jump_o <= '0;
        end else begin
            wb_o   <= wb_d;
            jump_o <= jump_i;
        end
    end

endmodule

/* logic/ex_top.sv */
`timescale 1ns/1ns

module ex_top (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  ex_pkg::ex_in_t          ex_in_i,
    input  logic [ex_pkg::xlen-1:0] mem_rdata_i,
    output ex_pkg::ex_mem_t         mem_o,
    output ex_pkg::ex_wb_t          wb_o,
    output ex_pkg::ex_jump_t        jump_o
);

    import ex_pkg::*;

    ex_class_e       ex_class;
    alu_req_t        alu_req;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] load_data;
    ex_jump_t        jump;

    ex_decode ex_decode_inst (
        .ex_in_i   (ex_in_i),
        .class_o   (ex_class),
        .alu_req_o (alu_req)
    );

    ex_alu ex_alu_inst (
        .alu_req_i (alu_req),
        .result_o  (alu_result)
    );

    ex_branch ex_branch_inst (
        .class_i (ex_class),
        .ex_in_i (ex_in_i),
        .jump_o  (jump)
    );

    // same-cycle memory port
    ex_mem_align ex_mem_align_inst (
        .class_i     (ex_class),
        .ex_in_i     (ex_in_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_o       (mem_o),
        .load_data_o (load_data)
    );

    ex_result_reg ex_result_reg_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .class_i      (ex_class),
        .ex_in_i      (ex_in_i),
        .alu_result_i (alu_result),
        .load_data_i  (load_data),
        .jump_i       (jump),
        .wb_o         (wb_o),
        .jump_o       (jump_o)
    );

endmodule

/* bench/ex_top_tb.sv */
`timescale 1ns/1ns

module ex_top_tb;

    import ex_pkg::*;

    localparam int n_vec      = 22;
    localparam int vec_words  = 17;
    localparam int max_cycles = n_vec + 20;

    logic            clk;
    logic            rst_n_i;
    ex_in_t          ex_in_i;
    logic [xlen-1:0] mem_rdata_i;
    ex_mem_t         mem_o;
    ex_wb_t          wb_o;
    ex_jump_t        jump_o;

    logic [31:0] golden [0:n_vec*vec_words-1];
    int          cycle_cnt;

    ex_top ex_top_inst (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ex_in_i     (ex_in_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_o       (mem_o),
        .wb_o        (wb_o),
        .jump_o      (jump_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_mem(input string name, input ex_mem_t exp, input ex_mem_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Error: %s mem_o expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_wb(input string name, input ex_wb_t exp, input ex_wb_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Error: %s wb_o expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_jump(input string name, input ex_jump_t exp, input ex_jump_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("Error: %s jump_o expected %h actual %h", name, exp, act));
        end
    endtask

    // marker left in words the file does not overwrite
    function automatic logic [31:0] fill_word(input int idx);
        return 32'hdead_beef ^ idx;
    endfunction

    function automatic string describe_vector(input int idx, input logic [31:0] inst);
        string kind;
        case (inst[6:0])
            op_imm:    kind = "op_imm";
            op_reg:    kind = "op_reg";
            op_load:   kind = "load";
            op_store:  kind = "store";
            op_branch: kind = "branch";
            op_jal:    kind = "jal";
            op_jalr:   kind = "jalr";
            op_lui:    kind = "lui";
            default:   kind = "other";
        endcase
        return $sformatf("vector %0d (%s)", idx, kind);
    endfunction

    // word 1 holds we at bit 8, waddr in bits 4:0
    function automatic ex_in_t unpack_input(input int base);
        ex_in_t v;
        v.inst       = golden[base];
        v.reg_we     = golden[base+1][8];
        v.reg_waddr  = golden[base+1][4:0];
        v.reg1_rdata = golden[base+2];
        v.reg2_rdata = golden[base+3];
        v.op1        = golden[base+4];
        v.op2        = golden[base+5];
        v.op1_jump   = golden[base+6];
        v.op2_jump   = golden[base+7];
        return v;
    endfunction

    function automatic ex_mem_t mem_expect(input int base);
        ex_mem_t m;
        m.req   = golden[base+9][4];
        m.we    = golden[base+9][0];
        m.raddr = golden[base+10];
        m.waddr = golden[base+11];
        m.wdata = golden[base+12];
        return m;
    endfunction

    function automatic ex_wb_t wb_expect(input int base);
        ex_wb_t w;
        w.we    = golden[base+13][8];
        w.waddr = golden[base+13][4:0];
        w.wdata = golden[base+14];
        return w;
    endfunction

    function automatic ex_jump_t jump_expect(input int base);
        ex_jump_t j;
        j.flag = golden[base+15][0];
        j.addr = golden[base+16];
        return j;
    endfunction

    initial begin : replay
        ex_wb_t   exp_wb;
        ex_jump_t exp_jump;
        string    prev_name;
        int       base;
        void'($urandom(49134));
        rst_n_i     = 1'b0;
        ex_in_i     = '0;
        mem_rdata_i = '0;
        for (int k = 0; k < n_vec*vec_words; k++) begin
            golden[k] = fill_word(k);
        end
        $readmemh("bench/ex_golden.hex", golden);
        if (golden[0] === fill_word(0) ||
            golden[n_vec*vec_words-1] === fill_word(n_vec*vec_words-1)) begin
            stop_on_error("golden vector file is missing or shorter than expected");
        end
        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_wb("after reset", '0, wb_o);
        check_jump("after reset", '0, jump_o);
        // idle cycle ahead of vector 0 also registers zeros
        exp_wb    = '0;
        exp_jump  = '0;
        prev_name = "idle";
        for (int i = 0; i < n_vec; i++) begin
            base = i * vec_words;
            @(posedge clk);
            ex_in_i     <= unpack_input(base);
            mem_rdata_i <= golden[base+8];
            @(negedge clk);
            check_mem(describe_vector(i, golden[base]), mem_expect(base), mem_o); // same cycle
            check_wb(prev_name, exp_wb, wb_o);                                   // one cycle late
            check_jump(prev_name, exp_jump, jump_o);
            prev_name = describe_vector(i, golden[base]);
            exp_wb    = wb_expect(base);
            exp_jump  = jump_expect(base);
        end
        @(posedge clk);
        ex_in_i     <= '0;
        mem_rdata_i <= '0;
        @(negedge clk);
        check_wb(prev_name, exp_wb, wb_o);
        check_jump(prev_name, exp_jump, jump_o);
        $display("TESTS PASSED");
        $finish;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        stop_on_error($sformatf("timeout after %0d cycles before all vectors ran", cycle_cnt));
    end

endmodule

/* bench/ex_golden.hex */
// in: inst ctl(we bit 8, waddr 4:0) reg1 reg2 op1 op2 op1_jump op2_jump mem_rdata
// exp: mem(req bit 4, we bit 0) raddr waddr wdata wb(we bit 8, waddr 4:0) wb_wdata jump_flag jump_addr
12308293 00000105 00001000 00000000 00001000 00000123 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000105 00001123 00000000 00000000
40310333 00000106 00000005 00000007 00000005 00000007 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000106 fffffffe 00000000 00000000
003123b3 00000107 fffffff0 00000001 fffffff0 00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000107 00000001 00000000 00000000
00313433 00000108 fffffff0 00000001 fffffff0 00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000108 00000000 00000000 00000000
0040d493 00000109 80000f00 00000000 80000f00 00000004 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000109 080000f0 00000000 00000000
4040d513 0000010a 80000f00 00000000 80000f00 00000404 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000010a f80000f0 00000000 00000000
003115b3 0000010b 00000003 00000025 00000003 00000025 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000010b 00000060 00000000 00000000
123457b7 0000010f 00000000 00000000 00000000 12345000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0000010f 12345000 00000000 00000000
00208463 00000000 00000055 00000055 00000055 00000055 00000100 00000008 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000001 00000108
00209463 00000000 00000055 00000055 00000055 00000055 00000104 00000008 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
0020c463 00000000 ffffffff 00000001 ffffffff 00000001 00000200 fffffff0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000001 000001f0
0020f463 00000000 00000001 ffffffff 00000001 ffffffff 00000300 00000008 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
020000ef 00000101 00000000 00000000 00000400 00000004 00000400 00000020 00000000 00000000 00000000 00000000 00000000 00000101 00000404 00000001 00000420
008280e7 00000101 00002000 00000000 00000500 00000004 00002000 00000008 00000000 00000000 00000000 00000000 00000000 00000101 00000504 00000001 00002008
00108303 00000106 00001000 00000000 00001000 00000001 00000000 00000000 1122f344 00000010 00001001 00000000 00000000 00000106 fffffff3 00000000 00000000
0020d383 00000107 00001000 00000000 00001000 00000002 00000000 00000000 8765abcd 00000010 00001002 00000000 00000000 00000107 00008765 00000000 00000000
00009483 00000109 00001000 00000000 00001000 00000000 00000000 00000000 12348001 00000010 00001000 00000000 00000000 00000109 ffff8001 00000000 00000000
002081a3 00000000 00001000 cafe12ab 00001000 00000003 00000000 00000000 11223344 00000011 00001003 00001003 ab223344 00000000 00000000 00000000 00000000
00209123 00000000 00001000 cafe12ab 00001000 00000002 00000000 00000000 11223344 00000011 00001002 00001002 12ab3344 00000000 00000000 00000000 00000000
0020a423 00000000 00001000 cafe12ab 00001000 00000008 00000000 00000000 11223344 00000011 00001008 00001008 cafe12ab 00000000 00000000 00000000 00000000
022082b3 00000105 00000003 00000004 00000003 00000004 00000000 00000000 55555555 00000000 00000000 00000000 00000000 00000105 00000000 00000000 00000000
ffffffff 00000103 00000000 00000000 00000000 00000000 00000600 00000010 55555555 00000000 00000000 00000000 00000000 00000103 00000000 00000000 00000000

/* sim.f */
logic/ex_pkg.sv
logic/ex_decode.sv
logic/ex_alu.sv
logic/ex_branch.sv
logic/ex_mem_align.sv
logic/ex_result_reg.sv
logic/ex_top.sv
bench/ex_top_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ex_top_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the pass or fail result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
